// File: vlog.f
+incdir+verification
source/lane_queue_pkg.sv
source/fifo_status_if.sv
source/lane_compactor.sv
source/multi_fifo.sv
source/drain_packer.sv
source/queue_ctrl.sv
source/lane_queue_top.sv
verification/lane_queue_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module lane_queue_tb -Mdir "$OBJ"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/Vlane_queue_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
  exit 1
fi
exit 0

// File: verification/lane_queue_tests.svh
// sparse lanes in hold then drain in order
task automatic test_compaction();
  drive_cycle(4'b1010, 32'h1300_1100, CMD_HOLD);
  drive_cycle(4'b0111, 32'h0023_2221, CMD_NOP);
  drive_cycle(4'b1000, 32'h3400_0000, CMD_NOP);
  drive_cycle('0, '0, CMD_NOP);
  @(negedge clk);
  if (level !== 5'd6) report_err("level", 6, level);
  drive_cycle('0, '0, CMD_RUN);
  drive_cycle('0, '0, CMD_NOP);
  wait_drained(20);
endtask

task automatic test_full_drop();
  logic [15:0] base;
  cmd_e        c;
  base = drop_count;
  for (int k = 0; k < 5; k++) begin
    if (k == 0) c = CMD_HOLD;
    else c = CMD_NOP;
    drive_cycle(4'b1111, make_words(8'h40 + 8'(4*k)), c);
  end
  drive_cycle('0, '0, CMD_NOP);
  @(negedge clk);
  if (level !== 5'd16) report_err("level", 16, level);
  if (full !== 1'b1) report_err("full", 1, full);
  if (drop_count !== base + 16'd4) report_err("drop_count", base + 16'd4, drop_count);
  drive_cycle('0, '0, CMD_RUN);
  drive_cycle('0, '0, CMD_NOP);
  wait_drained(30);
endtask

task automatic test_latency();
  int n;
  drive_cycle(4'b0001, 32'h0000_00a5, CMD_RUN);
  drive_cycle('0, '0, CMD_NOP);
  @(negedge clk);
  if (out_valid !== 4'b0000) report_err("out_valid", 0, out_valid);
  drive_cycle('0, '0, CMD_NOP);
  @(negedge clk);
  if (out_valid !== 4'b0001) report_err("out_valid", 4'b0001, out_valid);
  if (out_data[0] !== 8'ha5) report_err("out_data[0]", 8'ha5, out_data[0]);
  // ten words held and drained as 4 then 4 then 2
  drive_cycle(4'b1111, make_words(8'h50), CMD_HOLD);
  drive_cycle(4'b1111, make_words(8'h54), CMD_NOP);
  drive_cycle(4'b0011, make_words(8'h58), CMD_NOP);
  drive_cycle('0, '0, CMD_RUN);
  drive_cycle('0, '0, CMD_NOP);
  n = 0;
  @(negedge clk);
  while (out_valid == '0 && n < 10) begin
    @(negedge clk);
    n++;
  end
  if (out_valid !== 4'b1111) report_err("out_valid", 4'b1111, out_valid);
  @(negedge clk);
  if (out_valid !== 4'b1111) report_err("out_valid", 4'b1111, out_valid);
  @(negedge clk);
  if (out_valid !== 4'b0011) report_err("out_valid", 4'b0011, out_valid);
  wait_drained(10);
endtask

task automatic test_flush();
  logic [15:0] base;
  logic [4:0]  last;
  int n;
  base = drop_count;
  drive_cycle(4'b1111, make_words(8'h60), CMD_HOLD);
  drive_cycle(4'b1111, make_words(8'h64), CMD_NOP);
  drive_cycle(4'b0001, make_words(8'h68), CMD_NOP);
  drive_cycle('0, '0, CMD_FLUSH);
  drive_cycle(4'b0011, make_words(8'h70), CMD_NOP);  // dropped while flushing
  @(negedge clk);
  if (flushing !== 1'b1) report_err("flushing", 1, flushing);
  drive_cycle(4'b0011, make_words(8'h74), CMD_NOP);
  drive_cycle(4'b0011, make_words(8'h78), CMD_NOP);
  drive_cycle('0, '0, CMD_NOP);
  n = 0;
  @(negedge clk);
  last = level;
  while (flushing && n < 10) begin
    last = level;
    @(negedge clk);
    n++;
  end
  if (flushing) begin
    $display("flush did not finish within 10 cycles at %0t", $time);
    errors++;
  end
  if (last !== 5'd0) report_err("level", 0, last);
  if (drop_count !== base + 16'd6) report_err("drop_count", base + 16'd6, drop_count);
  wait_drained(10);
endtask

task automatic test_clear();
  drive_cycle(4'b1111, make_words(8'h80), CMD_HOLD);
  drive_cycle(4'b0011, make_words(8'h84), CMD_NOP);
  drive_cycle('0, '0, CMD_CLEAR);
  drive_cycle('0, '0, CMD_NOP);
  @(negedge clk);
  if (level !== 5'd0) report_err("level", 0, level);
  if (empty !== 1'b1) report_err("empty", 1, empty);
  drive_cycle('0, '0, CMD_RUN);
  drive_cycle('0, '0, CMD_NOP);
  repeat (6) begin
    @(negedge clk);
    if (out_valid !== 4'b0000) report_err("out_valid", 0, out_valid);  // stale word
  end
endtask

task automatic test_random();
  logic [M-1:0]   mask;
  logic [M*W-1:0] data;
  cmd_e           c;
  for (int k = 0; k < 300; k++) begin
    mask = M'($random(seed));
    data = $random(seed);
    if (k % 20 == 0) c = CMD_RUN;
    else if (k % 20 == 8) c = CMD_HOLD;  // long hold forces drops
    else c = CMD_NOP;
    drive_cycle(mask, data, c);
  end
  drive_cycle('0, '0, CMD_RUN);
  drive_cycle('0, '0, CMD_NOP);
  wait_drained(20);
  if (drop_count !== m_drops) report_err("drop_count", m_drops, drop_count);
endtask

// File: verification/lane_queue_tb.sv
`timescale 1ns/1ps

module lane_queue_tb
  import lane_queue_pkg::*;
();

  localparam int W     = 8;
  localparam int M     = 4;
  localparam int N     = 4;
  localparam int DEPTH = 16;
  localparam int TEST_CYCLES = 40 + 60 + 50 + 50 + 40 + 420;  // per-test budgets

  logic                   clk;
  logic                   rst_n;
  logic [M-1:0]           in_valid;
  logic [M-1:0][W-1:0]    in_data;
  cmd_e                   cmd;
  logic [N-1:0]           out_valid;
  logic [N-1:0][W-1:0]    out_data;
  logic [$clog2(DEPTH):0] level;
  logic                   full;
  logic                   empty;
  logic                   flushing;
  logic [15:0]            drop_count;

  int                  errors;
  integer              seed;
  logic [W-1:0]        ref_q[$];  // words held by the fifo, oldest first
  ctrl_state_e         m_state;
  logic [15:0]         m_drops;
  logic [N-1:0]        exp_valid;  // expected output of the next cycle
  logic [N-1:0][W-1:0] exp_data;

  always #5 clk = ~clk;

  lane_queue_top i_dut (.*);

  task automatic report_err(input string name, input logic [31:0] exp_v,
                            input logic [31:0] act_v);
    $display("ERR %0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
    errors++;
  endtask

  task automatic drive_cycle(input logic [M-1:0] mask, input logic [M*W-1:0] data,
                             input cmd_e c);
    @(posedge clk);
    in_valid <= mask;
    in_data  <= data;
    cmd      <= c;
  endtask

  // words first, first+1, ... on lanes 0 upward
  function automatic logic [M*W-1:0] make_words(input logic [W-1:0] first);
    logic [M*W-1:0] w;
    for (int i = 0; i < M; i++) begin
      w[i*W +: W] = first + W'(i);
    end
    return w;
  endfunction

  task automatic wait_drained(input int max_cycles);
    int n;
    n = 0;
    @(negedge clk);
    while (!(empty && out_valid == '0) && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (!(empty && out_valid == '0)) begin
      $display("queue did not drain within %0d cycles at %0t", max_cycles, $time);
      errors++;
    end
  endtask

  `include "lane_queue_tests.svh"

  // reference queue, outputs and inputs are stable at the falling edge
  always @(negedge clk) begin
    int held;
    int dense;
    int acc;
    int npop;
    int n;
    logic clr;
    if (!rst_n) begin
      ref_q.delete();
      m_state   = ST_HOLD;
      m_drops   = '0;
      exp_valid = '0;
      exp_data  = '0;
    end else begin
      held = ref_q.size();
      if (out_valid !== exp_valid)
        report_err("out_valid", exp_valid, out_valid);
      for (int i = 0; i < N; i++) begin
        if (exp_valid[i] && out_data[i] !== exp_data[i])
          report_err($sformatf("out_data[%0d]", i), exp_data[i], out_data[i]);
      end
      if (level !== held[$clog2(DEPTH):0])
        report_err("level", held, level);
      if (flushing !== (m_state == ST_FLUSH))
        report_err("flushing", m_state == ST_FLUSH, flushing);
      if (drop_count !== m_drops)
        report_err("drop_count", m_drops, drop_count);
      // this cycle, free space counted before the pops
      clr   = (cmd == CMD_CLEAR);
      dense = $countones(in_valid);
      acc   = (m_state == ST_FLUSH || clr) ? 0 : ((dense < DEPTH - held) ? dense : DEPTH - held);
      npop  = (m_state == ST_HOLD || clr) ? 0 : ((held < N) ? held : N);
      if (int'(m_drops) + dense - acc > 65535)
        m_drops = 16'hffff;
      else
        m_drops = 16'(int'(m_drops) + dense - acc);
      exp_valid = '0;
      for (int i = 0; i < npop; i++) begin
        exp_valid[i] = 1'b1;
        exp_data[i]  = ref_q.pop_front();
      end
      n = 0;
      if (clr)
        ref_q.delete();
      for (int i = 0; i < M; i++) begin
        if (in_valid[i] && !clr) begin
          if (n < acc) ref_q.push_back(in_data[i]);  // lane order
          n++;
        end
      end
      case (cmd)
        CMD_HOLD:  m_state = ST_HOLD;
        CMD_RUN:   m_state = ST_RUN;
        CMD_FLUSH: m_state = ST_FLUSH;
        default: if (m_state == ST_FLUSH && held == 0) m_state = ST_RUN;
      endcase
    end
  end

  initial begin
    #(2 * TEST_CYCLES * 10);
    $display("watchdog fired, the run timed out at %0t", $time);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    errors   = 0;
    seed     = 32'h4b74_a9c3;
    clk      = 1'b0;
    rst_n    = 1'b0;
    in_valid = '0;
    in_data  = '0;
    cmd      = CMD_NOP;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    test_compaction();
    test_full_drop();
    test_latency();
    test_flush();
    test_clear();
    test_random();
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// File: source/lane_queue_top.sv
`timescale 1ns/1ps

module lane_queue_top
  import lane_queue_pkg::*;
#(
  parameter int W     = 8,
  parameter int M     = 4,
  parameter int N     = 4,
  parameter int DEPTH = 16
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [M-1:0]           in_valid,
  input  logic [M-1:0][W-1:0]    in_data,
  input  cmd_e                   cmd,
  output logic [N-1:0]           out_valid,
  output logic [N-1:0][W-1:0]    out_data,
  output logic [$clog2(DEPTH):0] level,
  output logic                   full,
  output logic                   empty,
  output logic                   flushing,
  output logic [15:0]            drop_count
);

  logic [M-1:0]        dense_mask;
  logic [M-1:0][W-1:0] dense_data;
  logic [M-1:0]        accept_mask;
  logic [N-1:0]        pop;
  logic [N-1:0][W-1:0] dataout;
  logic                clear;

  fifo_status_if #(.M(M), .N(N), .DEPTH(DEPTH)) status_if ();

  lane_compactor #(.W(W), .M(M)) u_compactor (
    .in_valid   (in_valid),
    .in_data    (in_data),
    .dense_mask (dense_mask),
    .dense_data (dense_data)
  );

  queue_ctrl #(.M(M), .N(N), .DEPTH(DEPTH)) u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .dense_mask  (dense_mask),
    .status      (status_if),
    .accept_mask (accept_mask),
    .pop         (pop),
    .clear       (clear),
    .flushing    (flushing),
    .drop_count  (drop_count)
  );

  multi_fifo #(.W(W), .M(M), .N(N), .DEPTH(DEPTH)) u_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear   (clear),
    .push    (accept_mask),  // only the accepted prefix is written
    .datain  (dense_data),
    .pop     (pop),
    .dataout (dataout),
    .status  (status_if)
  );

  drain_packer #(.W(W), .N(N)) u_packer (
    .clk       (clk),
    .rst_n     (rst_n),
    .pop       (pop),
    .dataout   (dataout),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  assign level = status_if.entry_count;
  assign full  = status_if.full;
  assign empty = status_if.empty;

endmodule

// File: source/queue_ctrl.sv
`timescale 1ns/1ps

module queue_ctrl
  import lane_queue_pkg::*;
#(
  parameter int M     = 4,
  parameter int N     = 4,
  parameter int DEPTH = 16
) (
  input  logic          clk,
  input  logic          rst_n,
  input  cmd_e          cmd,
  input  logic [M-1:0]  dense_mask,
  fifo_status_if.ctrl   status,
  output logic [M-1:0]  accept_mask,
  output logic [N-1:0]  pop,
  output logic          clear,
  output logic          flushing,
  output logic [15:0]   drop_count
);

  localparam int CW = $clog2(DEPTH) + 1;

  ctrl_state_e   state;
  ctrl_state_e   state_nxt;

  logic [CW-1:0] dense_cnt;
  logic [CW-1:0] free_cnt;
  logic [CW-1:0] acc_cnt;
  logic [CW-1:0] pop_cnt;
  logic [CW-1:0] drop_cnt;
  logic [16:0]   drop_sum;

  // command decode
  always_comb begin
    state_nxt = state;
    case (cmd)
      CMD_HOLD:  state_nxt = ST_HOLD;
      CMD_RUN:   state_nxt = ST_RUN;
      CMD_FLUSH: state_nxt = ST_FLUSH;
      default: begin  // nop and clear keep the state
        if (state == ST_FLUSH && status.entry_count == '0) begin
          state_nxt = ST_RUN;  // flush done
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_HOLD;
    end else begin
      state <= state_nxt;
    end
  end

  assign clear    = (cmd == CMD_CLEAR);
  assign flushing = (state == ST_FLUSH);

  // free space is taken before this cycle's pops
  assign dense_cnt = CW'($countones(dense_mask));
  assign free_cnt  = CW'(DEPTH) - status.entry_count;

  always_comb begin
    if (state == ST_FLUSH || clear) begin
      acc_cnt = '0;
    end else begin
      acc_cnt = (free_cnt < dense_cnt) ? free_cnt : dense_cnt;
    end
  end

  always_comb begin
    if (state == ST_HOLD || clear) begin
      pop_cnt = '0;
    end else begin
      pop_cnt = (status.entry_count < CW'(N)) ? status.entry_count : CW'(N);
    end
  end

  genvar i;
  generate
    for (i = 0; i < M; i++) begin : gen_accept
      assign accept_mask[i] = (i < acc_cnt);  // prefix of dense_mask
    end
    for (i = 0; i < N; i++) begin : gen_pop
      assign pop[i] = (i < pop_cnt);
    end
  endgenerate

  // rejected words are counted, saturating
  assign drop_cnt = dense_cnt - acc_cnt;
  assign drop_sum = {1'b0, drop_count} + 17'(drop_cnt);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      drop_count <= '0;
    end else if (drop_sum[16]) begin
      drop_count <= '1;
    end else begin
      drop_count <= drop_sum[15:0];
    end
  end

  // never ask the fifo for more words than it holds
  assert property (@(posedge clk) disable iff (!rst_n)
    $countones(pop) <= status.entry_count)
    else $error("queue_ctrl: pop of %0d words with %0d held",
                $countones(pop), status.entry_count);

endmodule

// File: source/drain_packer.sv
`timescale 1ns/1ps

module drain_packer #(
  parameter int W = 8,
  parameter int N = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [N-1:0]        pop,
  input  logic [N-1:0][W-1:0] dataout,
  output logic [N-1:0]        out_valid,
  output logic [N-1:0][W-1:0] out_data
);

  // valid mask follows pop one cycle later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= '0;
    end else begin
      out_valid <= pop;
    end
  end

  // only popped lanes load, others keep old words
  always_ff @(posedge clk) begin
    for (int i = 0; i < N; i++) begin
      if (pop[i]) begin
        out_data[i] <= dataout[i];
      end
    end
  end

  // the pop mask from the controller is a low-order prefix
  assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid & (out_valid + N'(1))) == '0)
    else $error("drain_packer: out_valid %b is not contiguous", out_valid);

endmodule

// File: source/multi_fifo.sv
`timescale 1ns/1ps

module multi_fifo #(
  parameter int W     = 8,
  parameter int M     = 4,
  parameter int N     = 4,
  parameter int DEPTH = 16
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                clear,
  input  logic [M-1:0]        push,     // dense, low lanes first
  input  logic [M-1:0][W-1:0] datain,
  input  logic [N-1:0]        pop,      // dense, low lanes first
  output logic [N-1:0][W-1:0] dataout,
  fifo_status_if.fifo         status
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = AW + 1;

  logic [W-1:0]  mem [DEPTH];  // no reset on storage

  logic [AW-1:0] wptr;
  logic [AW-1:0] rptr;
  logic [CW-1:0] count;
  logic [CW-1:0] push_count;
  logic [CW-1:0] pop_count;

  assign push_count = CW'($countones(push));
  assign pop_count  = CW'($countones(pop));

  // pointers and occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else if (clear) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      wptr  <= wptr + push_count[AW-1:0];  // wraps at DEPTH
      rptr  <= rptr + pop_count[AW-1:0];
      count <= count + push_count - pop_count;
    end
  end

  // lane j writes j slots past the write pointer
  always_ff @(posedge clk) begin
    if (!clear) begin
      for (int j = 0; j < M; j++) begin
        if (push[j] && !status.almost_full[j]) begin
          mem[wptr + AW'(j)] <= datain[j];
        end
      end
    end
  end

  // unregistered read, oldest word on lane 0
  genvar i;
  generate
    for (i = 0; i < N; i++) begin : gen_dataout
      assign dataout[i] = mem[rptr + AW'(i)];
    end
  endgenerate

  assign status.entry_count = count;
  assign status.full        = (count == CW'(DEPTH));
  assign status.empty       = (count == '0);

  generate
    for (i = 0; i < M; i++) begin : gen_almost_full
      assign status.almost_full[i] = (count + i >= DEPTH);
    end
    for (i = 0; i < N; i++) begin : gen_almost_empty
      assign status.almost_empty[i] = (count <= i);
    end
  endgenerate

  // the controller must never overrun or underrun the buffer
  generate
    for (i = 0; i < M; i++) begin : gen_chk_overflow
      assert property (@(posedge clk) disable iff (!rst_n)
        !(push[i] && !clear && status.almost_full[i]))
        else $error("multi_fifo: overflow on push lane %0d", i);
    end
    for (i = 0; i < N; i++) begin : gen_chk_underflow
      assert property (@(posedge clk) disable iff (!rst_n)
        !(pop[i] && !clear && status.almost_empty[i]))
        else $error("multi_fifo: underflow on pop lane %0d", i);
    end
  endgenerate

endmodule

// File: source/lane_compactor.sv
`timescale 1ns/1ps

module lane_compactor #(
  parameter int W = 8,
  parameter int M = 4
) (
  input  logic [M-1:0]        in_valid,
  input  logic [M-1:0][W-1:0] in_data,
  output logic [M-1:0]        dense_mask,
  output logic [M-1:0][W-1:0] dense_data
);

  // k-th valid lane lands in dense lane k
  always_comb begin
    int n;
    n          = 0;
    dense_mask = '0;
    dense_data = '0;
    for (int i = 0; i < M; i++) begin
      if (in_valid[i]) begin
        dense_mask[n] = 1'b1;
        dense_data[n] = in_data[i];
        n++;
      end
    end
  end

  // dense lanes must form a low-order run of ones
  always_comb begin
    assert ((dense_mask & (dense_mask + M'(1))) == '0)
      else $error("lane_compactor: dense_mask %b is not contiguous", dense_mask);
  end

endmodule

// File: source/fifo_status_if.sv
`timescale 1ns/1ps

interface fifo_status_if #(
  parameter int M     = 4,
  parameter int N     = 4,
  parameter int DEPTH = 16
);

  logic                       full;
  logic [M-1:0]               almost_full;   // [i] set when i or fewer entries free
  logic                       empty;
  logic [N-1:0]               almost_empty;  // [i] set when i or fewer words held
  logic [$clog2(DEPTH):0]     entry_count;

  // fifo side drives the occupancy view
  modport fifo (
    output full,
    output almost_full,
    output empty,
    output almost_empty,
    output entry_count
  );

  // controller only looks at it
  modport ctrl (
    input full,
    input almost_full,
    input empty,
    input almost_empty,
    input entry_count
  );

endinterface

// File: source/lane_queue_pkg.sv
package lane_queue_pkg;

  // one-cycle command, sampled at the rising edge
  typedef enum logic [2:0] {
    CMD_NOP   = 3'd0,  // keep current state
    CMD_HOLD  = 3'd1,  // stop draining, keep filling
    CMD_RUN   = 3'd2,  // fill and drain
    CMD_FLUSH = 3'd3,  // drain only, new words dropped
    CMD_CLEAR = 3'd4   // empty the fifo at the next edge
  } cmd_e;

  // controller state
  typedef enum logic [1:0] {
    ST_HOLD  = 2'd0,
    ST_RUN   = 2'd1,
    ST_FLUSH = 2'd2   // back to ST_RUN once the fifo is empty
  } ctrl_state_e;

endpackage
